//--- list.f
+incdir+logic
logic/pad_ctrl_pkg.sv
logic/sync_stage.sv
logic/pad_regs.sv
logic/pad_mux.sv
logic/pad_ctrl_top.sv
tb/pad_ctrl_sva.sv
tb/tb_pad_ctrl.sv

//--- Makefile
# Verilator build and run of the pad control testbench

SIM := obj_dir/Vtb_pad_ctrl

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the result"
	@echo "  clean  remove the build directory"

$(SIM): list.f $(wildcard logic/*.sv logic/*.svh tb/*.sv)
	verilator --binary --timing --assert --top-module tb_pad_ctrl -Mdir obj_dir -f list.f

test: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir

//--- tb/tb_pad_ctrl.sv
// Testbench for the pad control top level
// Random register traffic and pad stimulus against a reference model
// Per-test report lines and a closing count line

`include "pad_ctrl_defines.svh"

module tb_pad_ctrl import pad_ctrl_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_ITER  = 180;
  localparam int IDX_W   = $clog2(`PAD_CTRL_N_PADS);
  localparam int N_WR    = 3 + `PAD_CTRL_N_PADS;       // Writable addresses
  localparam int TIMEOUT = 2 * (11 * N_ITER + 38);     // Twice the summed test lengths

  logic         ref_clk;
  logic         rst_n;
  logic         reg_we;
  reg_addr_t    reg_addr;
  reg_data_t    reg_wdata;
  reg_data_t    reg_rdata;
  pad_vec_t     pad_in, pad_out, pad_oe;
  pad_vec_t     func_out, func_oe, func_in;
  pad_cfg_arr_t pad_cfg;
  boot_sel_t    bootsel, bootsel_q;

  // Reference model of the writable registers
  reg_data_t    m_padmux;
  pad_vec_t     m_gpio_out, m_gpio_dir;
  pad_cfg_arr_t m_cfg;

  integer seed = 32'h8529d31d;
  int errors = 0;
  int checks = 0;
  int cycle_cnt = 0;

  pad_ctrl_top UUT (
    .ref_clk_i   ( ref_clk   ),
    .rst_n_i     ( rst_n     ),
    .reg_we_i    ( reg_we    ),
    .reg_addr_i  ( reg_addr  ),
    .reg_wdata_i ( reg_wdata ),
    .reg_rdata_o ( reg_rdata ),
    .pad_in_i    ( pad_in    ),
    .bootsel_i   ( bootsel   ),
    .pad_out_o   ( pad_out   ),
    .pad_oe_o    ( pad_oe    ),
    .pad_cfg_o   ( pad_cfg   ),
    .func_out_i  ( func_out  ),
    .func_oe_i   ( func_oe   ),
    .func_in_o   ( func_in   ),
    .bootsel_o   ( bootsel_q )
  );

  initial ref_clk = 1'b0;
  always #2 ref_clk = ~ref_clk;

  always @(posedge ref_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
      $display("Verification failed");
      $finish;
    end
  end

  task automatic report_mismatch(input string name, input logic [127:0] exp,
                                 input logic [127:0] act);
    errors++;
    $display("Mismatch at %0d ns: %s expected %0h, got %0h", $time, name, exp, act);
  endtask

  // Called at a falling edge, returns at the next one with the read data valid
  task automatic bus_access(input logic we, input reg_addr_t addr, input reg_data_t data);
    reg_we    = we;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge ref_clk);
    reg_we = 1'b0;
  endtask

  task automatic model_write(input reg_addr_t addr, input reg_data_t data);
    int a;
    a = int'(addr);
    if (a >= `REG_PADCFG_BASE && a < `REG_PADCFG_BASE + `PAD_CTRL_N_PADS) begin
      m_cfg[IDX_W'(a - `REG_PADCFG_BASE)] = data[`PAD_CFG_WIDTH-1:0];
    end else if (a == `REG_PADMUX) begin
      m_padmux = data;
    end else if (a == `REG_GPIO_OUT) begin
      m_gpio_out = data[`PAD_CTRL_N_PADS-1:0];
    end else if (a == `REG_GPIO_DIR) begin
      m_gpio_dir = data[`PAD_CTRL_N_PADS-1:0];
    end
  endtask

  function automatic reg_data_t expected_read(input reg_addr_t addr);
    int a;
    a = int'(addr);
    if (a >= `REG_PADCFG_BASE && a < `REG_PADCFG_BASE + `PAD_CTRL_N_PADS) begin
      return reg_data_t'(m_cfg[IDX_W'(a - `REG_PADCFG_BASE)]);
    end
    case (a)
      `REG_PADMUX:   return m_padmux;
      `REG_GPIO_OUT: return reg_data_t'(m_gpio_out);
      `REG_GPIO_DIR: return reg_data_t'(m_gpio_dir);
      default:       return '0;
    endcase
  endfunction

  // Index 0..2 maps to the GPIO and mux words, the rest to the config window
  function automatic reg_addr_t writable_addr(input int n);
    if (n < 3) return reg_addr_t'(n);
    return reg_addr_t'(`REG_PADCFG_BASE + n - 3);
  endfunction

  task automatic check_read(input reg_addr_t addr);
    checks++;
    if (reg_rdata !== expected_read(addr)) begin
      report_mismatch("reg_rdata_o", 128'(expected_read(addr)), 128'(reg_rdata));
    end
  endtask

  task automatic check_pads();
    pad_vec_t   exp_out;
    pad_vec_t   exp_oe;
    pad_vec_t   exp_fin;
    logic [1:0] sel;
    exp_out = '0;
    exp_oe  = '0;
    exp_fin = '0;
    for (int i = 0; i < `PAD_CTRL_N_PADS; i++) begin
      sel = m_padmux[2*i +: 2];
      if (sel == PAD_SEL_FUNC) begin
        exp_out[i] = func_out[i];
        exp_oe[i]  = func_oe[i];
        exp_fin[i] = pad_in[i];
      end else if (sel == PAD_SEL_GPIO) begin
        exp_out[i] = m_gpio_out[i];
        exp_oe[i]  = m_gpio_dir[i];
      end
    end
    checks += 3;
    if (pad_out !== exp_out) report_mismatch("pad_out_o", 128'(exp_out), 128'(pad_out));
    if (pad_oe !== exp_oe) report_mismatch("pad_oe_o", 128'(exp_oe), 128'(pad_oe));
    if (func_in !== exp_fin) report_mismatch("func_in_o", 128'(exp_fin), 128'(func_in));
  endtask

  task automatic check_cfg();
    checks++;
    if (pad_cfg !== m_cfg) report_mismatch("pad_cfg_o", 128'(m_cfg), 128'(pad_cfg));
  endtask

  // Inputs reach the read register three edges after being driven
  task automatic sample_inputs(input bit boot_side);
    pad_vec_t  hist_pad[$];
    boot_sel_t hist_boot[$];
    reg_addr = boot_side ? reg_addr_t'(`REG_BOOTSEL) : reg_addr_t'(`REG_GPIO_IN);
    repeat (3) @(negedge ref_clk);
    repeat (3) begin
      hist_pad.push_back(pad_in);
      hist_boot.push_back(bootsel);
    end
    for (int n = 0; n < N_ITER; n++) begin
      checks++;
      if (!boot_side && reg_rdata !== reg_data_t'(hist_pad[0])) begin
        report_mismatch("reg_rdata_o", 128'(hist_pad[0]), 128'(reg_rdata));
      end
      if (boot_side) begin
        checks++;
        if (bootsel_q !== hist_boot[1]) begin
          report_mismatch("bootsel_o", 128'(hist_boot[1]), 128'(bootsel_q));
        end
        if (reg_rdata !== reg_data_t'(hist_boot[0])) begin
          report_mismatch("reg_rdata_o", 128'(hist_boot[0]), 128'(reg_rdata));
        end
      end
      void'(hist_pad.pop_front());
      void'(hist_boot.pop_front());
      pad_in  = pad_vec_t'($random(seed));
      bootsel = boot_sel_t'($random(seed));
      hist_pad.push_back(pad_in);
      hist_boot.push_back(bootsel);
      @(negedge ref_clk);
    end
  endtask

  task automatic finish_test(input string name, input int mark);
    $display("%s: done at cycle %0d, %0d errors", name, cycle_cnt, errors - mark);
  endtask

  initial begin
    reg_data_t data;
    reg_addr_t addr;
    logic      we;
    int        mark;
    rst_n     = 1'b0;
    reg_we    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    pad_in    = pad_vec_t'($random(seed));
    bootsel   = boot_sel_t'($random(seed));
    func_out  = pad_vec_t'($random(seed));
    func_oe   = pad_vec_t'($random(seed));
    m_padmux  = '0;
    for (int i = 0; i < `PAD_CTRL_N_PADS; i++) m_padmux[2*i +: 2] = PAD_SEL_HIZ;
    m_gpio_out = '0;
    m_gpio_dir = '0;
    m_cfg      = '0;
    repeat (8) @(negedge ref_clk);
    rst_n = 1'b1;
    @(negedge ref_clk);

    mark = errors;
    check_pads();
    check_cfg();
    for (int n = 0; n < N_WR; n++) begin
      bus_access(1'b0, writable_addr(n), '0);
      check_read(writable_addr(n));
    end
    finish_test("Test 1 reset state", mark);

    mark = errors;
    for (int n = 0; n < N_ITER; n++) begin
      addr = writable_addr(int'($unsigned($random(seed)) % N_WR));
      data = reg_data_t'($random(seed));
      bus_access(1'b1, addr, data);
      model_write(addr, data);
      check_read(addr);
      check_cfg();
    end
    finish_test("Test 2 register writes", mark);

    mark = errors;
    for (int n = 0; n < N_ITER; n++) begin
      data = reg_data_t'($random(seed) & $random(seed));  // More function selects
      bus_access(1'b1, reg_addr_t'(`REG_PADMUX), data);
      model_write(reg_addr_t'(`REG_PADMUX), data);
      func_out = pad_vec_t'($random(seed));
      func_oe  = pad_vec_t'($random(seed));
      pad_in   = pad_vec_t'($random(seed));
      #1;
      check_pads();
      @(negedge ref_clk);
    end
    finish_test("Test 3 function routing", mark);

    mark = errors;
    for (int n = 0; n < N_ITER; n++) begin
      for (int r = `REG_PADMUX; r <= `REG_GPIO_DIR; r++) begin
        data = reg_data_t'($random(seed));
        bus_access(1'b1, reg_addr_t'(r), data);
        model_write(reg_addr_t'(r), data);
      end
      func_out = pad_vec_t'($random(seed));
      func_oe  = pad_vec_t'($random(seed));
      #1;
      check_pads();
      @(negedge ref_clk);
    end
    finish_test("Test 4 GPIO routing", mark);

    mark = errors;
    sample_inputs(1'b0);
    sample_inputs(1'b1);
    finish_test("Test 5 input sampling", mark);

    mark = errors;
    for (int n = 0; n < N_ITER; n++) begin
      addr = reg_addr_t'(`REG_GPIO_IN + int'($unsigned($random(seed)) % 13));
      we   = (int'(addr) <= `REG_BOOTSEL) ? 1'b1 : 1'($random(seed));
      bus_access(we, addr, reg_data_t'($random(seed)));
      if (int'(addr) > `REG_BOOTSEL) begin
        checks++;
        if (reg_rdata !== '0) report_mismatch("reg_rdata_o", 128'(0), 128'(reg_rdata));
      end
      check_cfg();
      addr = writable_addr(int'($unsigned($random(seed)) % N_WR));
      bus_access(1'b0, addr, '0);
      check_read(addr);
    end
    finish_test("Test 6 ignored accesses", mark);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- tb/pad_ctrl_sva.sv
// Bound assertions for the pad control top level
// Pad enables after reset, high impedance pads, function input gating

`include "pad_ctrl_defines.svh"

module pad_ctrl_sva import pad_ctrl_pkg::*; (
  input logic         ref_clk_i,
  input logic         rst_n_i,
  input pad_sel_arr_t pad_sel_i,
  input pad_vec_t     pad_out_i,
  input pad_vec_t     pad_oe_i,
  input pad_vec_t     func_in_i
);

  timeunit 1ns;
  timeprecision 100ps;

  pad_vec_t hiz_drive;  // Floating pad that still drives
  pad_vec_t func_leak;

  always_comb begin
    hiz_drive = '0;
    func_leak = '0;
    for (int i = 0; i < `PAD_CTRL_N_PADS; i++) begin
      if (pad_sel_i[i] == PAD_SEL_HIZ || pad_sel_i[i] == PAD_SEL_RSVD) begin
        hiz_drive[i] = pad_out_i[i] | pad_oe_i[i];
      end
      if (pad_sel_i[i] != PAD_SEL_FUNC) func_leak[i] = func_in_i[i];
    end
  end

  a_oe_after_reset: assert property (@(posedge ref_clk_i) $rose(rst_n_i) |-> pad_oe_i == '0)
    else $error("Pad output enable set in the cycle after reset release");

  a_hiz_quiet: assert property (@(posedge ref_clk_i) disable iff (!rst_n_i) hiz_drive == '0)
    else $error("High impedance pad drives out or enable");

  a_func_gated: assert property (@(posedge ref_clk_i) disable iff (!rst_n_i) func_leak == '0)
    else $error("Function input set on a pad not selected for its function");

endmodule

bind pad_ctrl_top pad_ctrl_sva sva_i (
  .ref_clk_i ( ref_clk_i ),
  .rst_n_i   ( rst_n_i   ),
  .pad_sel_i ( s_pad_sel ),
  .pad_out_i ( pad_out_o ),
  .pad_oe_i  ( pad_oe_o  ),
  .func_in_i ( func_in_o )
);

//--- logic/pad_ctrl_top.sv
// Pad control top level
// Input synchronizers, register block and pad mux

`include "pad_ctrl_defines.svh"

module pad_ctrl_top import pad_ctrl_pkg::*; (
  input  logic         ref_clk_i,
  input  logic         rst_n_i,

  input  logic         reg_we_i,
  input  reg_addr_t    reg_addr_i,
  input  reg_data_t    reg_wdata_i,
  output reg_data_t    reg_rdata_o,

  input  pad_vec_t     pad_in_i,
  input  boot_sel_t    bootsel_i,
  output pad_vec_t     pad_out_o,
  output pad_vec_t     pad_oe_o,
  output pad_cfg_arr_t pad_cfg_o,

  input  pad_vec_t     func_out_i,
  input  pad_vec_t     func_oe_i,
  output pad_vec_t     func_in_o,

  output boot_sel_t    bootsel_o
);

  pad_vec_t     s_gpio_in;
  pad_vec_t     s_gpio_out;
  pad_vec_t     s_gpio_dir;
  pad_sel_arr_t s_pad_sel;

  sync_stage #(
    .payload_t ( pad_vec_t   )
  ) gpio_sync (
    .ref_clk_i ( ref_clk_i   ),
    .rst_n_i   ( rst_n_i     ),
    .d_i       ( pad_in_i    ),
    .q_o       ( s_gpio_in   )
  );

  sync_stage #(
    .payload_t ( boot_sel_t  )
  ) boot_sync (
    .ref_clk_i ( ref_clk_i   ),
    .rst_n_i   ( rst_n_i     ),
    .d_i       ( bootsel_i   ),
    .q_o       ( bootsel_o   )
  );

  pad_regs pad_regs_i (
    .ref_clk_i   ( ref_clk_i   ),
    .rst_n_i     ( rst_n_i     ),
    .reg_we_i    ( reg_we_i    ),
    .reg_addr_i  ( reg_addr_i  ),
    .reg_wdata_i ( reg_wdata_i ),
    .gpio_in_i   ( s_gpio_in   ),
    .bootsel_i   ( bootsel_o   ),  // Synchronized copy
    .reg_rdata_o ( reg_rdata_o ),
    .pad_sel_o   ( s_pad_sel   ),
    .pad_cfg_o   ( pad_cfg_o   ),
    .gpio_out_o  ( s_gpio_out  ),
    .gpio_dir_o  ( s_gpio_dir  )
  );

  // Raw pad inputs feed the function side directly
  pad_mux pad_mux_i (
    .pad_sel_i  ( s_pad_sel  ),
    .func_out_i ( func_out_i ),
    .func_oe_i  ( func_oe_i  ),
    .gpio_out_i ( s_gpio_out ),
    .gpio_dir_i ( s_gpio_dir ),
    .pad_in_i   ( pad_in_i   ),
    .pad_out_o  ( pad_out_o  ),
    .pad_oe_o   ( pad_oe_o   ),
    .func_in_o  ( func_in_o  )
  );

endmodule

//--- logic/pad_mux.sv
// Per-pad function multiplexer
// Output value and enable select, gating of function inputs

`include "pad_ctrl_defines.svh"

module pad_mux import pad_ctrl_pkg::*; (
  input  pad_sel_arr_t pad_sel_i,
  input  pad_vec_t     func_out_i,
  input  pad_vec_t     func_oe_i,
  input  pad_vec_t     gpio_out_i,
  input  pad_vec_t     gpio_dir_i,
  input  pad_vec_t     pad_in_i,
  output pad_vec_t     pad_out_o,
  output pad_vec_t     pad_oe_o,
  output pad_vec_t     func_in_o
);

  always_comb begin
    pad_out_o = '0;
    pad_oe_o  = '0;
    func_in_o = '0;
    for (int i = 0; i < `PAD_CTRL_N_PADS; i++) begin
      case (pad_sel_i[i])
        PAD_SEL_FUNC: begin
          pad_out_o[i] = func_out_i[i];
          pad_oe_o[i]  = func_oe_i[i];
          func_in_o[i] = pad_in_i[i];  // Peripheral only sees its own pads
        end
        PAD_SEL_GPIO: begin
          pad_out_o[i] = gpio_out_i[i];
          pad_oe_o[i]  = gpio_dir_i[i];  // Dir 1 means output
        end
        default: begin
          // High impedance, out and enable stay low
          pad_out_o[i] = 1'b0;
          pad_oe_o[i]  = 1'b0;
        end
      endcase
    end
  end

endmodule

//--- logic/pad_regs.sv
// Pad control register block
// Pad mux, per-pad config, GPIO out and direction registers
// Registered read-back including GPIO inputs and boot select

`include "pad_ctrl_defines.svh"

module pad_regs import pad_ctrl_pkg::*; (
  input  logic         ref_clk_i,
  input  logic         rst_n_i,
  input  logic         reg_we_i,
  input  reg_addr_t    reg_addr_i,
  input  reg_data_t    reg_wdata_i,
  input  pad_vec_t     gpio_in_i,
  input  boot_sel_t    bootsel_i,
  output reg_data_t    reg_rdata_o,
  output pad_sel_arr_t pad_sel_o,
  output pad_cfg_arr_t pad_cfg_o,
  output pad_vec_t     gpio_out_o,
  output pad_vec_t     gpio_dir_o
);

  pad_sel_arr_t pad_sel_q, pad_sel_d;
  pad_cfg_arr_t pad_cfg_q, pad_cfg_d;
  pad_vec_t     gpio_out_q, gpio_out_d;
  pad_vec_t     gpio_dir_q, gpio_dir_d;
  reg_data_t    rdata_q, rdata_d;

  logic         cfg_hit;
  reg_addr_t    cfg_off;
  logic [$clog2(`PAD_CTRL_N_PADS)-1:0] cfg_idx;

  // Config window decode
  assign cfg_hit = (int'(reg_addr_i) >= `REG_PADCFG_BASE) &&
                   (int'(reg_addr_i) < `REG_PADCFG_BASE + `PAD_CTRL_N_PADS);
  assign cfg_off = reg_addr_i - reg_addr_t'(`REG_PADCFG_BASE);
  assign cfg_idx = cfg_off[$clog2(`PAD_CTRL_N_PADS)-1:0];

  // Next state after this cycle's write
  always_comb begin
    pad_sel_d  = pad_sel_q;
    pad_cfg_d  = pad_cfg_q;
    gpio_out_d = gpio_out_q;
    gpio_dir_d = gpio_dir_q;
    if (reg_we_i) begin
      if (cfg_hit) begin
        pad_cfg_d[cfg_idx] = pad_cfg_t'(reg_wdata_i);  // Upper bits dropped
      end else begin
        case (reg_addr_i)
          reg_addr_t'(`REG_PADMUX): begin
            for (int i = 0; i < `PAD_CTRL_N_PADS; i++) begin
              pad_sel_d[i] = pad_sel_t'(reg_wdata_i[2*i +: 2]);
            end
          end
          reg_addr_t'(`REG_GPIO_OUT): gpio_out_d = pad_vec_t'(reg_wdata_i);
          reg_addr_t'(`REG_GPIO_DIR): gpio_dir_d = pad_vec_t'(reg_wdata_i);
          default: ;  // Read-only and unmapped
        endcase
      end
    end
  end

  // Read-back sees the write of the same edge
  always_comb begin
    rdata_d = '0;
    if (cfg_hit) begin
      rdata_d = reg_data_t'(pad_cfg_d[cfg_idx]);
    end else begin
      case (reg_addr_i)
        reg_addr_t'(`REG_PADMUX):   rdata_d = reg_data_t'(pad_sel_d);
        reg_addr_t'(`REG_GPIO_OUT): rdata_d = reg_data_t'(gpio_out_d);
        reg_addr_t'(`REG_GPIO_DIR): rdata_d = reg_data_t'(gpio_dir_d);
        reg_addr_t'(`REG_GPIO_IN):  rdata_d = reg_data_t'(gpio_in_i);
        reg_addr_t'(`REG_BOOTSEL):  rdata_d = reg_data_t'(bootsel_i);
        default:                    rdata_d = '0;
      endcase
    end
  end

  always_ff @(posedge ref_clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `PAD_CTRL_N_PADS; i++) begin
        pad_sel_q[i] <= PAD_SEL_HIZ;  // All pads float out of reset
      end
      pad_cfg_q  <= '0;
      gpio_out_q <= '0;
      gpio_dir_q <= '0;
      rdata_q    <= '0;
    end else begin
      pad_sel_q  <= pad_sel_d;
      pad_cfg_q  <= pad_cfg_d;
      gpio_out_q <= gpio_out_d;
      gpio_dir_q <= gpio_dir_d;
      rdata_q    <= rdata_d;
    end
  end

  assign reg_rdata_o = rdata_q;
  assign pad_sel_o   = pad_sel_q;
  assign pad_cfg_o   = pad_cfg_q;
  assign gpio_out_o  = gpio_out_q;
  assign gpio_dir_o  = gpio_dir_q;

endmodule

//--- logic/sync_stage.sv
// Two-flop input synchronizer, generic payload type

`include "pad_ctrl_defines.svh"

module sync_stage import pad_ctrl_pkg::*; #(
  parameter type payload_t = pad_vec_t
) (
  input  logic     ref_clk_i,
  input  logic     rst_n_i,
  input  payload_t d_i,
  output payload_t q_o
);

  payload_t meta_q;  // First stage, may go metastable
  payload_t sync_q;

  always_ff @(posedge ref_clk_i) begin
    if (!rst_n_i) begin
      meta_q <= '0;
      sync_q <= '0;
    end else begin
      meta_q <= d_i;
      sync_q <= meta_q;
    end
  end

  assign q_o = sync_q;

endmodule

//--- logic/pad_ctrl_pkg.sv
// Pad control package
// Pad select encoding, per-pad vectors and arrays, register bus types

`include "pad_ctrl_defines.svh"

package pad_ctrl_pkg;

  typedef enum logic [1:0] {
    PAD_SEL_FUNC = 2'd0,  // Peripheral function
    PAD_SEL_GPIO = 2'd1,
    PAD_SEL_HIZ  = 2'd2,
    PAD_SEL_RSVD = 2'd3   // Treated as high impedance
  } pad_sel_t;

  typedef logic [`PAD_CTRL_N_PADS-1:0] pad_vec_t;

  typedef pad_sel_t [`PAD_CTRL_N_PADS-1:0] pad_sel_arr_t;

  typedef logic [`PAD_CFG_WIDTH-1:0] pad_cfg_t;

  typedef pad_cfg_t [`PAD_CTRL_N_PADS-1:0] pad_cfg_arr_t;

  typedef logic [1:0] boot_sel_t;

  typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;
  typedef logic [`REG_DATA_WIDTH-1:0] reg_data_t;

endpackage

//--- logic/pad_ctrl_defines.svh
// Pad control sizing macros
// Pad count, per-pad config width, register bus widths
// Register map addresses

`ifndef PAD_CTRL_DEFINES_SVH
`define PAD_CTRL_DEFINES_SVH

`define PAD_CTRL_N_PADS   16
`define PAD_CFG_WIDTH     6

`define REG_ADDR_WIDTH    5
`define REG_DATA_WIDTH    32

// Register map
`define REG_PADMUX        0   // 2 select bits per pad
`define REG_GPIO_OUT      1
`define REG_GPIO_DIR      2
`define REG_GPIO_IN       3   // Read only
`define REG_BOOTSEL       4   // Read only
`define REG_PADCFG_BASE   16  // One word per pad

`endif
